/* rtl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Data word width of the RV32 datapath
    localparam int XLEN = 32;

    // Full data word
    typedef logic [XLEN-1:0] word_t;

    // PC without its two always-zero low bits
    typedef logic [XLEN-3:0] pc_word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // CSR address space
    typedef logic [11:0] csr_idx_t;

    // CSR immediate from the rs1 field
    typedef logic [4:0] zimm_t;

    // ALU operand A source
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1  = 2'd0,
        ALU_OP1_SRC_PC   = 2'd1,
        ALU_OP1_SRC_CSR  = 2'd2,
        ALU_OP1_SRC_ZERO = 2'd3
    } alu_op1_src_e;

    // ALU operand B source
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS1  = 2'd0,
        ALU_OP2_SRC_RS2  = 2'd1,
        ALU_OP2_SRC_IMM  = 2'd2,
        ALU_OP2_SRC_FOUR = 2'd3
    } alu_op2_src_e;

    // RV32I integer operations
    // Codes 10 to 15 are unused and give zero
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'd0,
        ALU_OP_SUB  = 4'd1,
        ALU_OP_SLL  = 4'd2,
        ALU_OP_SLT  = 4'd3,
        ALU_OP_SLTU = 4'd4,
        ALU_OP_XOR  = 4'd5,
        ALU_OP_SRL  = 4'd6,
        ALU_OP_SRA  = 4'd7,
        ALU_OP_OR   = 4'd8,
        ALU_OP_AND  = 4'd9
    } alu_op_e;

    // Branch conditions
    // NEVER marks instructions that do not branch
    typedef enum logic [2:0] {
        CMP_OP_EQ    = 3'd0,
        CMP_OP_NE    = 3'd1,
        CMP_OP_LT    = 3'd2,
        CMP_OP_GE    = 3'd3,
        CMP_OP_LTU   = 3'd4,
        CMP_OP_GEU   = 3'd5,
        CMP_OP_NEVER = 3'd6
    } cmp_op_e;

    // CSR operand source, register or immediate form
    typedef enum logic {
        CSR_OP_SRC_RS1  = 1'b0,
        CSR_OP_SRC_ZIMM = 1'b1
    } csr_op_src_e;

    // CSR read-modify-write kind
    typedef enum logic [1:0] {
        CSR_ALU_OP_PASSTHRU = 2'd0,
        CSR_ALU_OP_BITSET   = 2'd1,
        CSR_ALU_OP_BITCLEAR = 2'd2
    } csr_alu_op_e;

endpackage

`default_nettype wire

/* rtl/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  exec_pkg::word_t   operand_a,
    input  exec_pkg::word_t   operand_b,
    input  exec_pkg::alu_op_e alu_op,
    output exec_pkg::word_t   alu_result
);
    import exec_pkg::*;

    // Shift amount from the low five bits of B
    logic [4:0] shamt;

    // Comparison flags for SLT and SLTU
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = operand_b[4:0];
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            ALU_OP_ADD: begin
                alu_result = operand_a + operand_b;
            end
            ALU_OP_SUB: begin
                alu_result = operand_a - operand_b;
            end
            ALU_OP_SLL: begin
                alu_result = operand_a << shamt;
            end
            // Set-less-than results are zero or one
            ALU_OP_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_OP_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_OP_XOR: begin
                alu_result = operand_a ^ operand_b;
            end
            ALU_OP_SRL: begin
                alu_result = operand_a >> shamt;
            end
            // Arithmetic shift keeps the sign bit
            ALU_OP_SRA: begin
                alu_result = word_t'($signed(operand_a) >>> shamt);
            end
            ALU_OP_OR: begin
                alu_result = operand_a | operand_b;
            end
            ALU_OP_AND: begin
                alu_result = operand_a & operand_b;
            end
            // Unused op codes
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exec_branch_comparator.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_branch_comparator (
    input  exec_pkg::word_t   rs1_val,
    input  exec_pkg::word_t   rs2_val,
    input  exec_pkg::cmp_op_e cmp_op,
    output logic              branch_taken
);
    import exec_pkg::*;

    // Three base relations, the rest are negations
    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    assign equal       = rs1_val == rs2_val;
    assign lt_signed   = $signed(rs1_val) < $signed(rs2_val);
    assign lt_unsigned = rs1_val < rs2_val;

    always_comb begin
        case (cmp_op)
            CMP_OP_EQ:  branch_taken = equal;
            CMP_OP_NE:  branch_taken = !equal;
            CMP_OP_LT:  branch_taken = lt_signed;
            CMP_OP_GE:  branch_taken = !lt_signed;
            CMP_OP_LTU: branch_taken = lt_unsigned;
            CMP_OP_GEU: branch_taken = !lt_unsigned;
            // Non-branch instructions never take
            CMP_OP_NEVER: begin
                branch_taken = 1'b0;
            end
            // Spare encoding
            default: begin
                branch_taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exec_csr_updater.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_csr_updater (
    input  exec_pkg::word_t       rs1_val,
    input  exec_pkg::zimm_t       csr_zimm,
    input  exec_pkg::word_t       csr_old_val,
    input  exec_pkg::csr_op_src_e csr_op_src,
    input  exec_pkg::csr_alu_op_e csr_alu_op,
    output exec_pkg::word_t       csr_new_val
);
    import exec_pkg::*;

    // Operand for the write, set or clear
    word_t csr_operand;

    // Register form or zero-extended immediate form
    always_comb begin
        case (csr_op_src)
            CSR_OP_SRC_RS1: begin
                csr_operand = rs1_val;
            end
            CSR_OP_SRC_ZIMM: begin
                csr_operand = {{(XLEN-$bits(zimm_t)){1'b0}}, csr_zimm};
            end
            default: begin
                csr_operand = rs1_val;
            end
        endcase
    end

    // CSRRW writes, CSRRS sets bits, CSRRC clears bits
    always_comb begin
        case (csr_alu_op)
            CSR_ALU_OP_PASSTHRU: csr_new_val = csr_operand;
            CSR_ALU_OP_BITSET:   csr_new_val = csr_old_val | csr_operand;
            CSR_ALU_OP_BITCLEAR: csr_new_val = csr_old_val & ~csr_operand;
            // Fourth encoding
            default: begin
                csr_new_val = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                   clk,
    input  logic                   rst_n,

    // Decode side
    input  logic                   d_valid,
    input  exec_pkg::pc_word_t     d_pc_word,
    input  exec_pkg::word_t        d_rs1_val,
    input  exec_pkg::word_t        d_rs2_val,
    input  exec_pkg::word_t        d_immediate,
    input  exec_pkg::word_t        d_csr_old_val,
    input  exec_pkg::zimm_t        d_csr_zimm,
    input  exec_pkg::alu_op1_src_e d_alu_op1_src,
    input  exec_pkg::alu_op2_src_e d_alu_op2_src,
    input  exec_pkg::alu_op_e      d_alu_op,
    input  exec_pkg::cmp_op_e      d_cmp_op,
    input  exec_pkg::csr_op_src_e  d_csr_op_src,
    input  exec_pkg::csr_alu_op_e  d_csr_alu_op,
    input  exec_pkg::reg_idx_t     d_rd_idx,
    input  logic                   d_rd_we,
    input  exec_pkg::csr_idx_t     d_csr_idx,

    // Hazard unit
    input  logic                   e_stall,
    input  logic                   e_flush,

    // Toward memory stage
    output logic                   e_valid,
    output exec_pkg::pc_word_t     e_pc_word,
    output exec_pkg::reg_idx_t     e_rd_idx,
    output logic                   e_rd_we,
    output exec_pkg::csr_idx_t     e_csr_idx,
    output exec_pkg::word_t        e_csr_old_val,
    output exec_pkg::word_t        e_csr_new_val,
    output exec_pkg::word_t        e_alu_result,
    output exec_pkg::word_t        e_rs2_val,
    output logic                   e_branch_taken
);
    import exec_pkg::*;

    // Input flops holding the decode item
    logic         valid_q;
    pc_word_t     pc_word_q;
    word_t        rs1_val_q;
    word_t        rs2_val_q;
    word_t        immediate_q;
    word_t        csr_old_val_q;
    zimm_t        csr_zimm_q;
    alu_op1_src_e alu_op1_src_q;
    alu_op2_src_e alu_op2_src_q;
    alu_op_e      alu_op_q;
    cmp_op_e      cmp_op_q;
    csr_op_src_e  csr_op_src_q;
    csr_alu_op_e  csr_alu_op_q;
    reg_idx_t     rd_idx_q;
    logic         rd_we_q;
    csr_idx_t     csr_idx_q;

    // Selected ALU operands
    word_t        operand_a;
    word_t        operand_b;

    // Valid bit, cleared by reset, frozen while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!e_stall) begin
            valid_q <= d_valid;
        end
    end

    // Payload captured on every unstalled edge
    always_ff @(posedge clk) begin
        if (!e_stall) begin
            pc_word_q     <= d_pc_word;
            rs1_val_q     <= d_rs1_val;
            rs2_val_q     <= d_rs2_val;
            immediate_q   <= d_immediate;
            csr_old_val_q <= d_csr_old_val;
            csr_zimm_q    <= d_csr_zimm;
            alu_op1_src_q <= d_alu_op1_src;
            alu_op2_src_q <= d_alu_op2_src;
            alu_op_q      <= d_alu_op;
            cmp_op_q      <= d_cmp_op;
            csr_op_src_q  <= d_csr_op_src;
            csr_alu_op_q  <= d_csr_alu_op;
            rd_idx_q      <= d_rd_idx;
            rd_we_q       <= d_rd_we;
            csr_idx_q     <= d_csr_idx;
        end
    end

    // Operand A, the PC form rebuilds the byte address
    always_comb begin
        case (alu_op1_src_q)
            ALU_OP1_SRC_RS1:  operand_a = rs1_val_q;
            ALU_OP1_SRC_PC:   operand_a = {pc_word_q, 2'b00};
            ALU_OP1_SRC_CSR:  operand_a = csr_old_val_q;
            ALU_OP1_SRC_ZERO: operand_a = '0;
            default:          operand_a = '0;
        endcase
    end

    // Operand B, FOUR serves the link address
    always_comb begin
        case (alu_op2_src_q)
            ALU_OP2_SRC_RS1:  operand_b = rs1_val_q;
            ALU_OP2_SRC_RS2:  operand_b = rs2_val_q;
            ALU_OP2_SRC_IMM:  operand_b = immediate_q;
            ALU_OP2_SRC_FOUR: operand_b = word_t'(4);
            default:          operand_b = '0;
        endcase
    end

    exec_alu u_alu (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_op     (alu_op_q),
        .alu_result (e_alu_result)
    );

    exec_branch_comparator u_branch_comparator (
        .rs1_val      (rs1_val_q),
        .rs2_val      (rs2_val_q),
        .cmp_op       (cmp_op_q),
        .branch_taken (e_branch_taken)
    );

    exec_csr_updater u_csr_updater (
        .rs1_val     (rs1_val_q),
        .csr_zimm    (csr_zimm_q),
        .csr_old_val (csr_old_val_q),
        .csr_op_src  (csr_op_src_q),
        .csr_alu_op  (csr_alu_op_q),
        .csr_new_val (e_csr_new_val)
    );

    // Strobe killed by flush, held off during stall
    assign e_valid = valid_q && !e_stall && !e_flush;

    // Fields forwarded unchanged to later stages
    assign e_pc_word     = pc_word_q;
    assign e_rd_idx      = rd_idx_q;
    assign e_rd_we       = rd_we_q;
    assign e_csr_idx     = csr_idx_q;
    assign e_csr_old_val = csr_old_val_q;
    assign e_rs2_val     = rs2_val_q;

endmodule

`default_nettype wire

/* sim/exec_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   d_valid,
    input  exec_pkg::pc_word_t     d_pc_word,
    input  exec_pkg::word_t        d_rs1_val,
    input  exec_pkg::word_t        d_rs2_val,
    input  exec_pkg::word_t        d_immediate,
    input  exec_pkg::word_t        d_csr_old_val,
    input  exec_pkg::zimm_t        d_csr_zimm,
    input  exec_pkg::alu_op1_src_e d_alu_op1_src,
    input  exec_pkg::alu_op2_src_e d_alu_op2_src,
    input  exec_pkg::alu_op_e      d_alu_op,
    input  exec_pkg::cmp_op_e      d_cmp_op,
    input  exec_pkg::csr_op_src_e  d_csr_op_src,
    input  exec_pkg::csr_alu_op_e  d_csr_alu_op,
    input  exec_pkg::reg_idx_t     d_rd_idx,
    input  logic                   d_rd_we,
    input  exec_pkg::csr_idx_t     d_csr_idx,
    input  logic                   e_stall,
    input  logic                   e_flush,
    input  logic                   e_valid,
    input  exec_pkg::pc_word_t     e_pc_word,
    input  exec_pkg::reg_idx_t     e_rd_idx,
    input  logic                   e_rd_we,
    input  exec_pkg::csr_idx_t     e_csr_idx,
    input  exec_pkg::word_t        e_csr_old_val,
    input  exec_pkg::word_t        e_csr_new_val,
    input  exec_pkg::word_t        e_alu_result,
    input  exec_pkg::word_t        e_rs2_val,
    input  logic                   e_branch_taken,
    output int                     err_count,
    output int                     checked_count
);
    import exec_pkg::*;

    // Decode item as it sits in the input flops
    typedef struct packed {
        pc_word_t     pc_word;
        word_t        rs1_val;
        word_t        rs2_val;
        word_t        immediate;
        word_t        csr_old_val;
        zimm_t        csr_zimm;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        alu_op_e      alu_op;
        cmp_op_e      cmp_op;
        csr_op_src_e  csr_op_src;
        csr_alu_op_e  csr_alu_op;
        reg_idx_t     rd_idx;
        logic         rd_we;
        csr_idx_t     csr_idx;
    } item_t;

    // Computed fields of one item
    typedef struct packed {
        word_t alu_result;
        logic  branch_taken;
        word_t csr_new_val;
    } result_t;

    // One-entry model of the flops
    item_t   held;
    logic    held_valid;
    result_t expected;
    logic    expected_valid;

    function automatic result_t exec_model(item_t it);
        word_t   a;
        word_t   b;
        word_t   fill;
        word_t   csr_src;
        logic    lt_s;
        logic    lt_u;
        logic    rs_lt_s;
        logic    rs_lt_u;
        result_t r;
        case (it.alu_op1_src)
            ALU_OP1_SRC_RS1: a = it.rs1_val;
            // Byte address of the instruction
            ALU_OP1_SRC_PC:  a = word_t'(it.pc_word) * 32'd4;
            ALU_OP1_SRC_CSR: a = it.csr_old_val;
            default:         a = 32'h0;
        endcase
        case (it.alu_op2_src)
            ALU_OP2_SRC_RS1: b = it.rs1_val;
            ALU_OP2_SRC_RS2: b = it.rs2_val;
            ALU_OP2_SRC_IMM: b = it.immediate;
            default:         b = 32'd4;
        endcase
        // Signed order decided by sign bits first
        lt_u = a < b;
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;
        // High bits refilled with the sign for SRA
        fill = {32{a[31]}} & ~(32'hffff_ffff >> b[4:0]);
        case (it.alu_op)
            ALU_OP_ADD:  r.alu_result = a + b;
            ALU_OP_SUB:  r.alu_result = a + ~b + 32'd1;
            ALU_OP_SLL:  r.alu_result = a << b[4:0];
            ALU_OP_SLT:  r.alu_result = {31'd0, lt_s};
            ALU_OP_SLTU: r.alu_result = {31'd0, lt_u};
            ALU_OP_XOR:  r.alu_result = a ^ b;
            ALU_OP_SRL:  r.alu_result = a >> b[4:0];
            ALU_OP_SRA:  r.alu_result = (a >> b[4:0]) | fill;
            ALU_OP_OR:   r.alu_result = a | b;
            ALU_OP_AND:  r.alu_result = a & b;
            default:     r.alu_result = 32'h0;
        endcase
        // Branch relations on the raw register values
        rs_lt_u = it.rs1_val < it.rs2_val;
        rs_lt_s = (it.rs1_val[31] != it.rs2_val[31]) ? it.rs1_val[31] : rs_lt_u;
        case (it.cmp_op)
            CMP_OP_EQ:  r.branch_taken = it.rs1_val == it.rs2_val;
            CMP_OP_NE:  r.branch_taken = it.rs1_val != it.rs2_val;
            CMP_OP_LT:  r.branch_taken = rs_lt_s;
            CMP_OP_GE:  r.branch_taken = !rs_lt_s;
            CMP_OP_LTU: r.branch_taken = rs_lt_u;
            CMP_OP_GEU: r.branch_taken = !rs_lt_u;
            default:    r.branch_taken = 1'b0;
        endcase
        // Immediate form is zero-extended
        csr_src = (it.csr_op_src == CSR_OP_SRC_ZIMM) ? {27'd0, it.csr_zimm} : it.rs1_val;
        case (it.csr_alu_op)
            CSR_ALU_OP_PASSTHRU: r.csr_new_val = csr_src;
            CSR_ALU_OP_BITSET:   r.csr_new_val = it.csr_old_val | csr_src;
            CSR_ALU_OP_BITCLEAR: r.csr_new_val = it.csr_old_val & ~csr_src;
            default:             r.csr_new_val = 32'h0;
        endcase
        return r;
    endfunction

    task automatic check_field(
        input string name,
        input word_t expected_val,
        input word_t actual
    );
        if (actual !== expected_val) begin
            $display("Error at %0d ns: %s expected %h, got %h",
                     $time, name, expected_val, actual);
            err_count++;
        end
    endtask

    // Outputs sampled before the flops update on this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            held_valid = 1'b0;
        end else begin
            expected_valid = held_valid && !e_stall && !e_flush;
            if (e_valid !== expected_valid) begin
                if (expected_valid) begin
                    $display("At %0d ns the stage dropped an item, e_valid was low", $time);
                end else begin
                    $display("At %0d ns e_valid was raised with no item due", $time);
                end
                err_count++;
            end else if (expected_valid) begin
                expected = exec_model(held);
                checked_count++;
                check_field("e_alu_result", expected.alu_result, e_alu_result);
                check_field("e_branch_taken", word_t'(expected.branch_taken),
                            word_t'(e_branch_taken));
                check_field("e_csr_new_val", expected.csr_new_val, e_csr_new_val);
                check_field("e_pc_word", word_t'(held.pc_word), word_t'(e_pc_word));
                check_field("e_rd_idx", word_t'(held.rd_idx), word_t'(e_rd_idx));
                check_field("e_rd_we", word_t'(held.rd_we), word_t'(e_rd_we));
                check_field("e_csr_idx", word_t'(held.csr_idx), word_t'(e_csr_idx));
                check_field("e_csr_old_val", held.csr_old_val, e_csr_old_val);
                check_field("e_rs2_val", held.rs2_val, e_rs2_val);
            end
            // Capture only on unstalled edges
            if (!e_stall) begin
                held_valid = d_valid;
                held = '{d_pc_word, d_rs1_val, d_rs2_val, d_immediate, d_csr_old_val,
                         d_csr_zimm, d_alu_op1_src, d_alu_op2_src, d_alu_op, d_cmp_op,
                         d_csr_op_src, d_csr_alu_op, d_rd_idx, d_rd_we, d_csr_idx};
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;
    import exec_pkg::*;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 4;
    localparam int NUM_CYCLES    = 2000;
    localparam int DRAIN_CYCLES  = 5;
    localparam int RUN_CYCLES    = RESET_CYCLES + IDLE_CYCLES + NUM_CYCLES + DRAIN_CYCLES;
    // Whole run plus ten percent
    localparam int TIMEOUT_NS    = RUN_CYCLES * CLK_PERIOD_NS * 11 / 10;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         d_valid;
    pc_word_t     d_pc_word;
    word_t        d_rs1_val;
    word_t        d_rs2_val;
    word_t        d_immediate;
    word_t        d_csr_old_val;
    zimm_t        d_csr_zimm;
    alu_op1_src_e d_alu_op1_src;
    alu_op2_src_e d_alu_op2_src;
    alu_op_e      d_alu_op;
    cmp_op_e      d_cmp_op;
    csr_op_src_e  d_csr_op_src;
    csr_alu_op_e  d_csr_alu_op;
    reg_idx_t     d_rd_idx;
    logic         d_rd_we;
    csr_idx_t     d_csr_idx;
    logic         e_stall;
    logic         e_flush;
    logic         e_valid;
    pc_word_t     e_pc_word;
    reg_idx_t     e_rd_idx;
    logic         e_rd_we;
    csr_idx_t     e_csr_idx;
    word_t        e_csr_old_val;
    word_t        e_csr_new_val;
    word_t        e_alu_result;
    word_t        e_rs2_val;
    logic         e_branch_taken;
    int           err_count;
    int           checked_count;

    // Stall phase bookkeeping
    int           stall_left;
    logic         prev_stall;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    exec_stage u_dut (.*);

    exec_checker u_checker (.*);

    // Corner values mixed with plain random words
    function automatic word_t random_word();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return word_t'($urandom_range(0, 40));
            default: return word_t'($urandom);
        endcase
    endfunction

    task automatic offer_item();
        d_pc_word     = pc_word_t'($urandom);
        d_rs1_val     = random_word();
        // Equal operands now and then for EQ, GE and GEU
        d_rs2_val     = ($urandom_range(0, 7) == 0) ? d_rs1_val : random_word();
        d_immediate   = random_word();
        d_csr_old_val = random_word();
        d_csr_zimm    = zimm_t'($urandom);
        d_alu_op1_src = alu_op1_src_e'($urandom_range(0, 3));
        d_alu_op2_src = alu_op2_src_e'($urandom_range(0, 3));
        d_alu_op      = alu_op_e'($urandom_range(0, 9));
        d_cmp_op      = cmp_op_e'($urandom_range(0, 6));
        d_csr_op_src  = csr_op_src_e'($urandom_range(0, 1));
        // Includes the unused fourth encoding
        d_csr_alu_op  = csr_alu_op_e'($urandom_range(0, 3));
        d_rd_idx      = reg_idx_t'($urandom);
        d_rd_we       = 1'($urandom_range(0, 1));
        d_csr_idx     = csr_idx_t'($urandom);
    endtask

    // One falling-edge update of strobe, stall and flush
    task automatic drive_cycle();
        if (stall_left > 0) begin
            stall_left--;
        end else if ($urandom_range(0, 29) == 0) begin
            stall_left = $urandom_range(1, 4);
        end
        e_stall = (stall_left > 0);
        e_flush = ($urandom_range(0, 19) == 0);
        // Item not captured last edge is offered again
        if (!prev_stall) begin
            d_valid = ($urandom_range(0, 3) != 0);
            offer_item();
        end
        prev_stall = e_stall;
    endtask

    initial begin
        void'($urandom(32'h57dd_213c));
        rst_n      = 1'b0;
        // Strobes during reset must not survive it
        d_valid    = 1'b1;
        e_stall    = 1'b0;
        e_flush    = 1'b0;
        stall_left = 0;
        prev_stall = 1'b0;
        offer_item();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n   = 1'b1;
        d_valid = 1'b0;
        // Quiet cycles, e_valid must stay low
        repeat (IDLE_CYCLES) @(negedge clk);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_cycle();
            @(negedge clk);
        end
        d_valid = 1'b0;
        e_stall = 1'b0;
        e_flush = 1'b0;
        repeat (DRAIN_CYCLES - 1) @(negedge clk);
        $display("Checked %0d items, counted %0d errors", checked_count, err_count);
        if (err_count == 0 && checked_count > 0) begin
            $display("No errors");
        end else begin
            if (checked_count == 0) begin
                $display("No item ever reached the e_valid strobe");
            end
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/exec_branch_comparator.sv
rtl/exec_csr_updater.sv
rtl/exec_stage.sv
sim/exec_checker.sv
sim/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_exec_stage \
    -Mdir "$BUILD_DIR" -o tb_exec_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_exec_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict from the log
if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
